// ==== rtl/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

    // ------------------------------------------------------------
    // Widths and constants
    // ------------------------------------------------------------

    localparam int unsigned XLEN = 32;

    // First fetch address after reset
    localparam logic [XLEN-1:0] BOOT_PC = 32'h0000_1000;

    // ------------------------------------------------------------
    // Memory interface
    // ------------------------------------------------------------

    typedef enum logic [1:0] {
        MEM_ACC_INSTR,
        MEM_ACC_LOAD,
        MEM_ACC_STORE
    } mem_acc_t;

    typedef struct packed {
        mem_acc_t           acc_type;
        logic [XLEN-1:0]    addr;
        logic [XLEN-1:0]    value;      // write data, unused for reads
    } mem_req_t;

    typedef struct packed {
        mem_acc_t           acc_type;
        logic [XLEN-1:0]    addr;
        logic [XLEN-1:0]    value;      // read data
    } mem_ans_t;

    // ------------------------------------------------------------
    // Load-store unit and fetch outputs
    // ------------------------------------------------------------

    typedef struct packed {
        logic               is_store;
        logic [XLEN-1:0]    addr;
        logic [XLEN-1:0]    wdata;
    } lsu_cmd_t;

    // Zero read data for stores
    typedef struct packed {
        logic               is_store;
        logic [XLEN-1:0]    addr;
        logic [XLEN-1:0]    rdata;
    } lsu_res_t;

    typedef struct packed {
        logic [XLEN-1:0]    pc;
        logic [XLEN-1:0]    instr;
    } instr_t;

endpackage

`default_nettype wire

// ==== rtl/prio_2way_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

module prio_2way_arbiter #(
    parameter type DATA_T = logic
) (
    // Requesting sources
    input  logic    high_prio_valid_i,
    input  logic    low_prio_valid_i,
    input  DATA_T   high_prio_data_i,
    input  DATA_T   low_prio_data_i,

    // Shared sink
    input  logic    ready_i,
    output logic    valid_o,
    output DATA_T   data_o,

    // Ready back to the sources
    output logic    high_prio_ready_o,
    output logic    low_prio_ready_o
);

    // Fixed priority, high source wins whenever it is valid
    always_comb begin : arb_select
        high_prio_ready_o = 1'b0;
        low_prio_ready_o  = 1'b0;

        if (high_prio_valid_i) begin
            valid_o           = 1'b1;
            data_o            = high_prio_data_i;
            high_prio_ready_o = ready_i;
        end else begin
            valid_o           = low_prio_valid_i;
            data_o            = low_prio_data_i;
            low_prio_ready_o  = ready_i;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/fetch_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module fetch_unit
    import mem_pkg::*;
(
    input  logic                clk_i,
    input  logic                arst_n_i,

    // Redirect command, single cycle
    input  logic                redirect_valid_i,
    input  logic [XLEN-1:0]     redirect_pc_i,

    // Request towards the arbiter
    output logic                mem_valid_o,
    input  logic                mem_ready_i,
    output mem_req_t            mem_req_o,

    // Answer from the router
    input  logic                ans_valid_i,
    output logic                ans_ready_o,
    input  mem_ans_t            ans_i,

    // Instruction output
    output logic                instr_valid_o,
    input  logic                instr_ready_i,
    output instr_t              instr_o
);

    logic [XLEN-1:0]    pc_q;
    logic               pend_q;
    logic               drop_q;
    logic               buf_valid_q;
    instr_t             buf_q;

    logic               mem_hs;
    logic               ans_hs;
    logic               instr_hs;

    // ------------------------------------------------------------
    // Handshakes
    // ------------------------------------------------------------

    // One read in flight; next one goes out as the buffer drains
    assign mem_valid_o = ~pend_q & (~buf_valid_q | instr_ready_i);
    assign ans_ready_o = drop_q | ~buf_valid_q | instr_ready_i;

    assign mem_hs   = mem_valid_o & mem_ready_i;
    assign ans_hs   = ans_valid_i & ans_ready_o;
    assign instr_hs = buf_valid_q & instr_ready_i;

    assign mem_req_o.acc_type = MEM_ACC_INSTR;
    assign mem_req_o.addr     = pc_q;
    assign mem_req_o.value    = '0;

    assign instr_valid_o = buf_valid_q;
    assign instr_o       = buf_q;

    // ------------------------------------------------------------
    // Control state
    // ------------------------------------------------------------

    always_ff @(posedge clk_i or negedge arst_n_i) begin : ctrl_regs
        if (!arst_n_i) begin
            pc_q        <= BOOT_PC;
            pend_q      <= 1'b0;
            drop_q      <= 1'b0;
            buf_valid_q <= 1'b0;
        end else begin
            // PC
            if (redirect_valid_i) begin
                pc_q <= redirect_pc_i;
            end else if (mem_hs) begin
                pc_q <= pc_q + XLEN'(4);
            end

            // Outstanding read
            if (mem_hs) begin
                pend_q <= 1'b1;
            end else if (ans_hs) begin
                pend_q <= 1'b0;
            end

            // A read issued before the redirect comes back stale
            if (redirect_valid_i && (mem_hs || (pend_q && !ans_hs))) begin
                drop_q <= 1'b1;
            end else if (ans_hs) begin
                drop_q <= 1'b0;
            end

            // Output buffer
            if (redirect_valid_i) begin
                buf_valid_q <= 1'b0;
            end else if (ans_hs && !drop_q) begin
                buf_valid_q <= 1'b1;
            end else if (instr_hs) begin
                buf_valid_q <= 1'b0;
            end
        end
    end

    // Buffer payload
    always_ff @(posedge clk_i) begin : buf_data
        if (ans_hs && !drop_q) begin
            buf_q.pc    <= ans_i.addr;
            buf_q.instr <= ans_i.value;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/lsu.sv ====
`timescale 1ns/10ps
`default_nettype none

module lsu
    import mem_pkg::*;
(
    input  logic        clk_i,
    input  logic        arst_n_i,

    // Commands from outside
    input  logic        cmd_valid_i,
    output logic        cmd_ready_o,
    input  lsu_cmd_t    cmd_i,

    // Request towards the arbiter
    output logic        mem_valid_o,
    input  logic        mem_ready_i,
    output mem_req_t    mem_req_o,

    // Answer from the router
    input  logic        ans_valid_i,
    output logic        ans_ready_o,
    input  mem_ans_t    ans_i,

    // Results to outside
    output logic        res_valid_o,
    input  logic        res_ready_i,
    output lsu_res_t    res_o
);

    typedef enum logic [1:0] {
        LSU_IDLE,
        LSU_REQ,
        LSU_RESP
    } lsu_state_t;

    lsu_state_t state_q;
    logic       res_valid_q;
    lsu_cmd_t   cmd_q;
    lsu_res_t   res_q;

    // ------------------------------------------------------------
    // Outputs
    // ------------------------------------------------------------

    assign cmd_ready_o = (state_q == LSU_IDLE);
    assign mem_valid_o = (state_q == LSU_REQ);

    // Answer taken only while the result slot is free
    assign ans_ready_o = (state_q == LSU_RESP) & ~res_valid_q;

    assign mem_req_o.acc_type = cmd_q.is_store ? MEM_ACC_STORE : MEM_ACC_LOAD;
    assign mem_req_o.addr     = cmd_q.addr;
    assign mem_req_o.value    = cmd_q.wdata;

    assign res_valid_o = res_valid_q;
    assign res_o       = res_q;

    // ------------------------------------------------------------
    // Controller
    // ------------------------------------------------------------

    always_ff @(posedge clk_i or negedge arst_n_i) begin : fsm
        if (!arst_n_i) begin
            state_q     <= LSU_IDLE;
            res_valid_q <= 1'b0;
        end else begin
            case (state_q)
                LSU_IDLE: begin
                    if (cmd_valid_i) state_q <= LSU_REQ;
                end
                LSU_REQ: begin
                    if (mem_ready_i) state_q <= LSU_RESP;
                end
                LSU_RESP: begin
                    if (ans_valid_i && !res_valid_q) begin
                        res_valid_q <= 1'b1;
                    end else if (res_valid_q && res_ready_i) begin
                        // result leaves, ready for the next command
                        res_valid_q <= 1'b0;
                        state_q     <= LSU_IDLE;
                    end
                end
                default: state_q <= LSU_IDLE;
            endcase
        end
    end

    // Command and result payloads
    always_ff @(posedge clk_i) begin : payload
        if (cmd_valid_i && cmd_ready_o) begin
            cmd_q <= cmd_i;
        end
        if (ans_valid_i && ans_ready_o) begin
            res_q.is_store <= cmd_q.is_store;
            res_q.addr     <= cmd_q.addr;
            res_q.rdata    <= cmd_q.is_store ? '0 : ans_i.value;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/mem_ans_router.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_ans_router
    import mem_pkg::*;
(
    // From memory
    input  logic        mem_valid_i,
    input  mem_ans_t    mem_ans_i,
    output logic        mem_ready_o,

    // To fetch unit
    output logic        fe_valid_o,
    input  logic        fe_ready_i,

    // To load-store unit
    output logic        lsu_valid_o,
    input  logic        lsu_ready_i
);

    // Steer by access type, instruction reads go to fetch
    always_comb begin : ans_decode
        fe_valid_o  = 1'b0;
        lsu_valid_o = 1'b0;
        mem_ready_o = 1'b0;

        if (mem_valid_i) begin
            if (mem_ans_i.acc_type == MEM_ACC_INSTR) begin
                fe_valid_o  = 1'b1;
                mem_ready_o = fe_ready_i;
            end else begin
                lsu_valid_o = 1'b1;
                mem_ready_o = lsu_ready_i;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/datapath.sv ====
`timescale 1ns/10ps
`default_nettype none

module datapath
    import mem_pkg::*;
(
    input  logic                clk_i,
    input  logic                arst_n_i,

    // Redirect
    input  logic                redirect_valid_i,
    input  logic [XLEN-1:0]     redirect_pc_i,

    // Fetched instructions
    output logic                instr_valid_o,
    input  logic                instr_ready_i,
    output instr_t              instr_o,

    // Load-store commands and results
    input  logic                lsu_cmd_valid_i,
    output logic                lsu_cmd_ready_o,
    input  lsu_cmd_t            lsu_cmd_i,
    output logic                lsu_res_valid_o,
    input  logic                lsu_res_ready_i,
    output lsu_res_t            lsu_res_o,

    // Memory port
    output logic                mem_valid_o,
    input  logic                mem_ready_i,
    output mem_req_t            mem_req_o,
    input  logic                mem_valid_i,
    output logic                mem_ready_o,
    input  mem_ans_t            mem_ans_i
);

    // Fetch side
    logic       fe_mem_valid;
    logic       mem_fe_ready;
    mem_req_t   fe_mem_req;
    logic       mem_fe_valid;
    logic       fe_mem_ready;

    // Load-store side
    logic       lsu_mem_valid;
    logic       mem_lsu_ready;
    mem_req_t   lsu_mem_req;
    logic       mem_lsu_valid;
    logic       lsu_mem_ready;

    // ------------------------------------------------------------
    // Requesters
    // ------------------------------------------------------------

    fetch_unit u_fetch_unit (
        .clk_i            (clk_i),
        .arst_n_i         (arst_n_i),
        .redirect_valid_i (redirect_valid_i),
        .redirect_pc_i    (redirect_pc_i),
        .mem_valid_o      (fe_mem_valid),
        .mem_ready_i      (mem_fe_ready),
        .mem_req_o        (fe_mem_req),
        .ans_valid_i      (mem_fe_valid),
        .ans_ready_o      (fe_mem_ready),
        .ans_i            (mem_ans_i),
        .instr_valid_o    (instr_valid_o),
        .instr_ready_i    (instr_ready_i),
        .instr_o          (instr_o)
    );

    lsu u_lsu (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .cmd_valid_i (lsu_cmd_valid_i),
        .cmd_ready_o (lsu_cmd_ready_o),
        .cmd_i       (lsu_cmd_i),
        .mem_valid_o (lsu_mem_valid),
        .mem_ready_i (mem_lsu_ready),
        .mem_req_o   (lsu_mem_req),
        .ans_valid_i (mem_lsu_valid),
        .ans_ready_o (lsu_mem_ready),
        .ans_i       (mem_ans_i),
        .res_valid_o (lsu_res_valid_o),
        .res_ready_i (lsu_res_ready_i),
        .res_o       (lsu_res_o)
    );

    // ------------------------------------------------------------
    // Shared memory port
    // ------------------------------------------------------------

    // Fetch has priority over load-store
    prio_2way_arbiter #(
        .DATA_T (mem_req_t)
    ) u_mem_req_arbiter (
        .high_prio_valid_i (fe_mem_valid),
        .low_prio_valid_i  (lsu_mem_valid),
        .high_prio_data_i  (fe_mem_req),
        .low_prio_data_i   (lsu_mem_req),
        .ready_i           (mem_ready_i),
        .valid_o           (mem_valid_o),
        .data_o            (mem_req_o),
        .high_prio_ready_o (mem_fe_ready),
        .low_prio_ready_o  (mem_lsu_ready)
    );

    mem_ans_router u_mem_ans_router (
        .mem_valid_i (mem_valid_i),
        .mem_ans_i   (mem_ans_i),
        .mem_ready_o (mem_ready_o),
        .fe_valid_o  (mem_fe_valid),
        .fe_ready_i  (fe_mem_ready),
        .lsu_valid_o (mem_lsu_valid),
        .lsu_ready_i (lsu_mem_ready)
    );

endmodule

`default_nettype wire

// ==== verif/mem_model.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_model
    import mem_pkg::*;
(
    input  logic        clk_i,
    input  logic        arst_n_i,

    // Requests from the datapath
    input  logic        req_valid_i,
    output logic        req_ready_o,
    input  mem_req_t    req_i,

    // Answers to the datapath
    output logic        ans_valid_o,
    input  logic        ans_ready_i,
    output mem_ans_t    ans_o
);

    localparam int unsigned LATENCY = 3;

    // Sparse storage, only written words exist
    logic [XLEN-1:0]    words [logic [XLEN-1:0]];

    logic               active;
    logic               busy;
    int unsigned        wait_cnt;
    mem_ans_t           ans_q;

    // Handshakes sampled on the rising edge, outputs driven on the falling edge
    initial begin : serve
        req_ready_o = 1'b0;
        ans_valid_o = 1'b0;
        ans_o       = '0;
        ans_q       = '0;
        active      = 1'b0;
        busy        = 1'b0;
        wait_cnt    = 0;
        forever begin
            @(posedge clk_i);
            if (!arst_n_i) begin
                active = 1'b0;
                busy   = 1'b0;
            end else if (busy) begin
                active = 1'b1;
                if (ans_valid_o && ans_ready_i) begin
                    busy = 1'b0;
                end else if (wait_cnt != 0) begin
                    wait_cnt--;
                end
            end else if (req_valid_i && req_ready_o) begin
                busy           = 1'b1;
                wait_cnt       = LATENCY - 1;
                ans_q.acc_type = req_i.acc_type;
                ans_q.addr     = req_i.addr;
                case (req_i.acc_type)
                    MEM_ACC_INSTR: ans_q.value = req_i.addr ^ 32'hA5A5_0000;
                    MEM_ACC_STORE: begin
                        words[req_i.addr] = req_i.value;
                        ans_q.value       = '0;
                    end
                    default: begin
                        if (words.exists(req_i.addr)) begin
                            ans_q.value = words[req_i.addr];
                        end else begin
                            ans_q.value = req_i.addr + 32'd7;
                        end
                    end
                endcase
            end else begin
                active = 1'b1;
            end

            @(negedge clk_i);
            // Ready is random while idle
            req_ready_o = active && !busy && (($urandom % 4) != 0);
            ans_valid_o = busy && (wait_cnt == 0);
            ans_o       = ans_q;
        end
    end

endmodule

`default_nettype wire

// ==== verif/tb_datapath.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_datapath
    import mem_pkg::*;
();

    // Run limit of 400 transfers at about 10 cycles each
    localparam int unsigned N_TRANSFERS         = 400;
    localparam int unsigned CYCLES_PER_TRANSFER = 10;
    localparam int unsigned MAX_CYCLES          = N_TRANSFERS * CYCLES_PER_TRANSFER;
    localparam int unsigned N_RANDOM_CMDS       = 40;

    logic               clk;
    logic               arst_n;
    logic               redirect_valid;
    logic [XLEN-1:0]    redirect_pc;
    logic               instr_valid;
    logic               instr_ready;
    instr_t             instr;
    logic               lsu_cmd_valid;
    logic               lsu_cmd_ready;
    lsu_cmd_t           lsu_cmd;
    logic               lsu_res_valid;
    logic               lsu_res_ready;
    lsu_res_t           lsu_res;
    logic               mem_req_valid;
    logic               mem_req_ready;
    mem_req_t           mem_req;
    logic               mem_ans_valid;
    logic               mem_ans_ready;
    mem_ans_t           mem_ans;

    // Reference state
    logic [XLEN-1:0]    expected_pc;
    lsu_res_t           exp_q [$];
    logic [XLEN-1:0]    shadow [logic [XLEN-1:0]];
    int unsigned        instr_count;
    int unsigned        cmd_count;
    int unsigned        res_count;

    datapath i_dut (
        .clk_i            (clk),
        .arst_n_i         (arst_n),
        .redirect_valid_i (redirect_valid),
        .redirect_pc_i    (redirect_pc),
        .instr_valid_o    (instr_valid),
        .instr_ready_i    (instr_ready),
        .instr_o          (instr),
        .lsu_cmd_valid_i  (lsu_cmd_valid),
        .lsu_cmd_ready_o  (lsu_cmd_ready),
        .lsu_cmd_i        (lsu_cmd),
        .lsu_res_valid_o  (lsu_res_valid),
        .lsu_res_ready_i  (lsu_res_ready),
        .lsu_res_o        (lsu_res),
        .mem_valid_o      (mem_req_valid),
        .mem_ready_i      (mem_req_ready),
        .mem_req_o        (mem_req),
        .mem_valid_i      (mem_ans_valid),
        .mem_ready_o      (mem_ans_ready),
        .mem_ans_i        (mem_ans)
    );

    mem_model i_mem_model (
        .clk_i       (clk),
        .arst_n_i    (arst_n),
        .req_valid_i (mem_req_valid),
        .req_ready_o (mem_req_ready),
        .req_i       (mem_req),
        .ans_valid_o (mem_ans_valid),
        .ans_ready_i (mem_ans_ready),
        .ans_o       (mem_ans)
    );

    // ------------------------------------------------------------
    // Reference and checking
    // ------------------------------------------------------------

    function automatic logic [XLEN-1:0] instr_word(input logic [XLEN-1:0] pc);
        return pc ^ 32'hA5A5_0000;
    endfunction

    // Expected result that also tracks stored words
    function automatic lsu_res_t lsu_result(input lsu_cmd_t cmd);
        lsu_res_t res;
        res.is_store = cmd.is_store;
        res.addr     = cmd.addr;
        if (cmd.is_store) begin
            res.rdata          = '0;
            shadow[cmd.addr]   = cmd.wdata;
        end else if (shadow.exists(cmd.addr)) begin
            res.rdata = shadow[cmd.addr];
        end else begin
            res.rdata = cmd.addr + 32'd7;
        end
        return res;
    endfunction

    task automatic check(input string name, input logic [127:0] actual,
                         input logic [127:0] expected);
        if (actual !== expected) begin
            $display("** Error at %0t ns: %s = 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
            $display("Testbench failed");
            $fatal(1, "Value mismatch");
        end
    endtask

    always @(posedge clk) begin : compare
        if (!arst_n) begin
            expected_pc = BOOT_PC;
            instr_count = 0;
            cmd_count   = 0;
            res_count   = 0;
        end else begin
            if (instr_valid && instr_ready) begin
                check("instr_o", 128'(instr),
                      128'({expected_pc, instr_word(expected_pc)}));
                expected_pc = expected_pc + 32'd4;
                instr_count++;
            end
            // Redirect wins over the instruction taken in the same cycle
            if (redirect_valid) begin
                expected_pc = redirect_pc;
            end
            if (lsu_cmd_valid && lsu_cmd_ready) begin
                exp_q.push_back(lsu_result(lsu_cmd));
                cmd_count++;
            end
            if (lsu_res_valid && lsu_res_ready) begin
                if (exp_q.size() == 0) begin
                    $display("LSU result at %0t ns with no command outstanding", $time);
                    $display("Testbench failed");
                    $fatal(1, "Unexpected result");
                end else begin
                    check("lsu_res_o", 128'(lsu_res), 128'(exp_q.pop_front()));
                    res_count++;
                end
            end
        end
    end

    // ------------------------------------------------------------
    // Clock, ready stalls and watchdog
    // ------------------------------------------------------------

    initial begin : clock_gen
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin : drive_ready
        instr_ready   = 1'b0;
        lsu_res_ready = 1'b0;
        forever begin
            @(negedge clk);
            instr_ready   = 1'($urandom % 2);
            lsu_res_ready = (($urandom % 3) != 0);
        end
    end

    initial begin : watchdog
        int unsigned cycles;
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display("Testbench failed");
        $fatal(1, "Timeout");
    end

    // ------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------

    task automatic wait_instrs(input int unsigned n);
        int unsigned target;
        target = instr_count + n;
        while (instr_count < target) @(negedge clk);
    endtask

    task automatic redirect_to(input logic [XLEN-1:0] pc);
        @(negedge clk);
        redirect_valid = 1'b1;
        redirect_pc    = pc;
        @(negedge clk);
        redirect_valid = 1'b0;
    endtask

    task automatic issue_cmd(input logic is_store, input logic [XLEN-1:0] addr,
                             input logic [XLEN-1:0] wdata);
        @(negedge clk);
        lsu_cmd_valid    = 1'b1;
        lsu_cmd.is_store = is_store;
        lsu_cmd.addr     = addr;
        lsu_cmd.wdata    = wdata;
        while (!lsu_cmd_ready) @(negedge clk);
        @(negedge clk);
        lsu_cmd_valid = 1'b0;
    endtask

    initial begin : stimulus
        logic               is_store;
        logic [XLEN-1:0]    addr;
        void'($urandom(16));
        arst_n         = 1'b0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        lsu_cmd_valid  = 1'b0;
        lsu_cmd        = '0;

        // Outputs stay low in reset and in the first cycle after it
        repeat (8) begin
            @(negedge clk);
            check("instr_valid_o", 128'(instr_valid), 128'(0));
            check("lsu_res_valid_o", 128'(lsu_res_valid), 128'(0));
            check("mem_ready_o", 128'(mem_ans_ready), 128'(0));
        end
        arst_n = 1'b1;
        @(negedge clk);
        check("instr_valid_o", 128'(instr_valid), 128'(0));
        check("lsu_res_valid_o", 128'(lsu_res_valid), 128'(0));
        check("mem_ready_o", 128'(mem_ans_ready), 128'(0));

        wait_instrs(40);
        redirect_to(32'h0000_2000);
        wait_instrs(20);
        redirect_to(32'h0000_3ff0);
        wait_instrs(20);

        // Store then load back, then a word never written
        issue_cmd(1'b1, 32'h0000_8000, 32'hDEAD_BEEF);
        issue_cmd(1'b0, 32'h0000_8000, '0);
        issue_cmd(1'b0, 32'h0000_8040, '0);

        // Mixed traffic on a small window of addresses
        repeat (N_RANDOM_CMDS) begin
            is_store = 1'($urandom % 2);
            addr     = 32'h0000_9000 + (($urandom % 8) * 4);
            issue_cmd(is_store, addr, $urandom);
        end

        while (res_count < cmd_count) @(negedge clk);
        wait_instrs(4);

        // LSU back to idle with no stray result
        check("lsu_res_valid_o", 128'(lsu_res_valid), 128'(0));
        check("lsu_cmd_ready_o", 128'(lsu_cmd_ready), 128'(1));
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
rtl/mem_pkg.sv
rtl/prio_2way_arbiter.sv
rtl/fetch_unit.sv
rtl/lsu.sv
rtl/mem_ans_router.sv
rtl/datapath.sv
verif/mem_model.sv
verif/tb_datapath.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the datapath testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_datapath -f all.f -o sim_datapath
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/sim_datapath
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation ended with status $status"
    exit "$status"
fi

exit 0
